/* list.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_width_adapter.sv
verilog/mem_arbiter.sv
verilog/mem_adapter_top.sv
tests/mem_adapter_checker.sv
tests/mem_adapter_tb.sv

/* run.sh */
#!/bin/bash
# builds with Verilator, runs, and judges the run from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mem_adapter_tb \
    -o mem_adapter_sim > build.log 2>&1 &&
./obj_dir/mem_adapter_sim > sim.log 2>&1 ||
echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

/* tests/mem_adapter_checker.sv */
`timescale 1ns/1ns

module mem_adapter_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 narrow_req_valid,
    input mem_pkg::narrow_req_t narrow_req,
    input logic                 narrow_req_ready,
    input logic                 narrow_rsp_valid,
    input mem_pkg::narrow_rsp_t narrow_rsp,
    input logic                 narrow_rsp_ready,
    input logic                 wide_req_valid,
    input mem_pkg::wide_req_t   wide_req,
    input logic                 wide_req_ready,
    input logic                 wide_rsp_valid,
    input mem_pkg::wide_rsp_t   wide_rsp,
    input logic                 wide_rsp_ready,
    input logic                 mem_req_valid,
    input mem_pkg::mem_req_t    mem_req,
    input logic                 mem_req_ready,
    input logic                 mem_rsp_valid,
    input mem_pkg::mem_rsp_t    mem_rsp,
    input logic                 mem_rsp_ready
);

    // a stalled stream keeps valid and payload.
    a_narrow_req_stable: assert property (@(posedge clk) disable iff (reset)
        narrow_req_valid && !narrow_req_ready |=> narrow_req_valid && $stable(narrow_req))
        else $error("narrow_req changed while stalled");

    a_wide_req_stable: assert property (@(posedge clk) disable iff (reset)
        wide_req_valid && !wide_req_ready |=> wide_req_valid && $stable(wide_req))
        else $error("wide_req changed while stalled");

    a_mem_req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while stalled");

    a_mem_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid && $stable(mem_rsp))
        else $error("mem_rsp changed while stalled");

    a_narrow_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        narrow_rsp_valid && !narrow_rsp_ready |=> narrow_rsp_valid && $stable(narrow_rsp))
        else $error("narrow_rsp changed while stalled");

    a_wide_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        wide_rsp_valid && !wide_rsp_ready |=> wide_rsp_valid && $stable(wide_rsp))
        else $error("wide_rsp changed while stalled");

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !narrow_rsp_valid && !wide_rsp_valid && !mem_req_valid)
        else $error("valid output high right after reset");

    a_wide_ready_gated: assert property (@(posedge clk) disable iff (reset)
        !mem_req_ready |-> !wide_req_ready)
        else $error("wide_req_ready high while mem_req_ready low");

endmodule

bind mem_adapter_top mem_adapter_checker checker_i (.*);

/* tests/mem_adapter_tb.sv */
`timescale 1ns/1ns

`include "mem_defines.svh"

module mem_adapter_tb;

    localparam int TEST_COUNT = 6;
    localparam int TEST_CYCLES = 3000;  // generous bound per test.

    logic clk, reset;
    logic narrow_req_valid, narrow_req_ready, narrow_rsp_valid, narrow_rsp_ready;
    logic wide_req_valid, wide_req_ready, wide_rsp_valid, wide_rsp_ready;
    logic mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    mem_pkg::narrow_req_t narrow_req;
    mem_pkg::narrow_rsp_t narrow_rsp;
    mem_pkg::wide_req_t   wide_req;
    mem_pkg::wide_rsp_t   wide_rsp;
    mem_pkg::mem_req_t    mem_req;
    mem_pkg::mem_rsp_t    mem_rsp;

    logic [63:0] mem_words [int];
    logic [31:0] ref_words [int];     // 32-bit word view.
    mem_pkg::mem_rsp_t    rsp_q [$];
    int unsigned          due_q [$];
    mem_pkg::narrow_rsp_t narrow_exp_q [$];
    mem_pkg::wide_rsp_t   wide_exp_q [$];
    mem_pkg::mem_req_t    narrow_seen;
    mem_pkg::mem_req_t    wide_beats [2];
    int unsigned cycle;
    int errors, tests_ok, tests_bad, wide_accept_beat;
    logic [31:0] lfsr;
    logic check_alt, alt_seen, prev_src;

    mem_adapter_top dut_i (.*);

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[126:0], lfsr[0]};
        end
        return v;
    endfunction

    // unwritten memory words read back a pattern of their address.
    function automatic logic [63:0] fill_word(input int a);
        return {32'(a) ^ 32'hc3c3_0000, ~32'(a)};
    endfunction

    function automatic logic [31:0] ref_get(input int m);
        logic [63:0] f;
        if (ref_words.exists(m)) begin
            return ref_words[m];
        end
        f = fill_word(m >> 1);  // word m is half m mod 2 of memory word m/2.
        return m[0] ? f[63:32] : f[31:0];
    endfunction

    function automatic void ref_merge(input int m, input logic [3:0] be, input logic [31:0] d);
        logic [31:0] w;
        w = ref_get(m);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        ref_words[m] = w;
    endfunction

    // reads come back in order 3 cycles after acceptance.
    always @(posedge clk) begin : mem_model
        logic [63:0] word;
        mem_pkg::mem_rsp_t r;
        if (reset) begin
            mem_rsp_valid <= 1'b0;
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                word = mem_words.exists(mem_req.addr) ? mem_words[mem_req.addr]
                                                      : fill_word(mem_req.addr);
                if (mem_req.rw) begin
                    for (int b = 0; b < 8; b++) begin
                        if (mem_req.byteen[b]) begin
                            word[8*b +: 8] = mem_req.data[8*b +: 8];
                        end
                    end
                    mem_words[mem_req.addr] = word;
                end else begin
                    r.data = word;
                    r.tag  = mem_req.tag;
                    rsp_q.push_back(r);
                    due_q.push_back(cycle + 3);
                end
                if (check_alt && alt_seen && narrow_req_valid && wide_req_valid) begin
                    assert (mem_req.tag[`MEM_TAG_WIDTH-1] != prev_src) else begin
                        $display("grant did not alternate between clients");
                        errors++;
                    end
                end
                prev_src = mem_req.tag[`MEM_TAG_WIDTH-1];
                alt_seen = check_alt;
            end
            if (rsp_q.size() > 0 && due_q[0] <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp <= rsp_q[0];
            end else begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : rsp_monitor
        mem_pkg::narrow_rsp_t ne;
        mem_pkg::wide_rsp_t we;
        if (!reset && narrow_rsp_valid && narrow_rsp_ready) begin
            if (narrow_exp_q.size() == 0) begin
                $display("unexpected narrow response with tag %h", narrow_rsp.tag);
                errors++;
            end else begin
                ne = narrow_exp_q.pop_front();
                assert (narrow_rsp == ne) else begin
                    $display("MISMATCH narrow_rsp got %h expected %h", narrow_rsp, ne);
                    errors++;
                end
            end
        end
        if (!reset && wide_rsp_valid && wide_rsp_ready) begin
            if (wide_exp_q.size() == 0) begin
                $display("unexpected wide response with tag %h", wide_rsp.tag);
                errors++;
            end else begin
                we = wide_exp_q.pop_front();
                assert (wide_rsp == we) else begin
                    $display("MISMATCH wide_rsp got %h expected %h", wide_rsp, we);
                    errors++;
                end
            end
        end
    end

    task automatic send_narrow(input int m, input logic rw, input logic [3:0] be,
                               input logic [31:0] d, input logic [1:0] tag);
        mem_pkg::narrow_req_t req;
        mem_pkg::narrow_rsp_t e;
        int n;
        req = '{addr: m, rw: rw, byteen: be, data: d, tag: tag};
        @(posedge clk);
        narrow_req_valid <= 1'b1;
        narrow_req <= req;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!narrow_req_ready && n < 500);
        if (!narrow_req_ready) begin
            $display("narrow request at word %h never accepted", m);
            errors++;
        end
        narrow_seen = mem_req;
        if (rw) begin
            ref_merge(m, be, d);
        end else begin
            e.data = ref_get(m);
            e.tag  = tag;
            narrow_exp_q.push_back(e);
        end
        narrow_req_valid <= 1'b0;
    endtask

    task automatic send_wide(input int line, input logic rw, input logic [15:0] be,
                             input logic [127:0] d, input logic [1:0] tag);
        mem_pkg::wide_req_t req;
        mem_pkg::wide_rsp_t e;
        int n, nb;
        req = '{addr: line, rw: rw, byteen: be, data: d, tag: tag};
        @(posedge clk);
        wide_req_valid <= 1'b1;
        wide_req <= req;
        n = 0;
        nb = 0;
        do begin
            @(posedge clk);
            n++;
            if (mem_req_valid && mem_req_ready && mem_req.tag[`MEM_TAG_WIDTH-1]) begin
                if (nb < 2) begin
                    wide_beats[nb] = mem_req;
                end
                nb++;
            end
        end while (!wide_req_ready && n < 500);
        if (!wide_req_ready) begin
            $display("wide request at line %h never accepted", line);
            errors++;
        end
        wide_accept_beat = nb;
        for (int k = 0; k < 4; k++) begin
            if (rw) begin
                ref_merge(4*line + k, be[4*k +: 4], d[32*k +: 32]);
            end
            e.data[32*k +: 32] = ref_get(4*line + k);
        end
        e.tag = tag;
        if (!rw) begin
            wide_exp_q.push_back(e);
        end
        wide_req_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((narrow_exp_q.size() != 0 || wide_exp_q.size() != 0) && n < 1000) begin
            @(posedge clk);
            n++;
        end
        if (narrow_exp_q.size() != 0 || wide_exp_q.size() != 0) begin
            $display("responses still missing after 1000 cycles");
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        if (errors == e0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("%s: %s, %0d errors", name, (errors == e0) ? "ok" : "FAIL", errors - e0);
    endtask

    task automatic narrow_write_read();
        int e0;
        e0 = errors;
        send_narrow(27'h15, 1'b1, 4'b0110, 32'hdeadbeef, 2'd2);
        assert (narrow_seen.addr == 26'ha) else begin
            $display("MISMATCH mem_req.addr got %h expected %h", narrow_seen.addr, 26'ha);
            errors++;
        end
        assert (narrow_seen.byteen == 8'h60 && narrow_seen.data == 64'hdeadbeef_00000000)
            else begin
            $display("MISMATCH mem_req.byteen/data got %h/%h expected 60/deadbeef00000000",
                     narrow_seen.byteen, narrow_seen.data);
            errors++;
        end
        assert (!narrow_seen.tag[`MEM_TAG_WIDTH-1]) else begin
            $display("MISMATCH mem_req.tag got %h expected top bit 0", narrow_seen.tag);
            errors++;
        end
        send_narrow(27'h15, 1'b0, 4'h0, 32'h0, 2'd1);
        wait_drain();
        finish_test("narrow write then read", e0);
    endtask

    task automatic wide_write_read();
        int e0;
        e0 = errors;
        send_wide(25'h40, 1'b1, 16'hffff, {64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888},
                  2'd3);
        assert (wide_beats[0].addr == 26'h80 && wide_beats[1].addr == 26'h81) else begin
            $display("MISMATCH mem_req.addr got %h,%h expected 80,81",
                     wide_beats[0].addr, wide_beats[1].addr);
            errors++;
        end
        assert (wide_beats[0].data == 64'h5555_6666_7777_8888 &&
                wide_beats[1].data == 64'h1111_2222_3333_4444) else begin
            $display("MISMATCH mem_req.data got %h,%h expected %h,%h",
                     wide_beats[0].data, wide_beats[1].data,
                     64'h5555_6666_7777_8888, 64'h1111_2222_3333_4444);
            errors++;
        end
        assert (wide_accept_beat == 2) else begin
            $display("MISMATCH wide_req_ready beat got %h expected 2", wide_accept_beat);
            errors++;
        end
        send_wide(25'h40, 1'b0, 16'h0, 128'h0, 2'd0);
        wait_drain();
        finish_test("wide write then read", e0);
    endtask

    task automatic mixed_views();
        int e0;
        e0 = errors;
        send_wide(25'h50, 1'b1, 16'hffff, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 2'd1);
        for (int k = 0; k < 4; k++) begin
            send_narrow(4*25'h50 + k, 1'b0, 4'h0, 32'h0, 2'(k));
        end
        for (int k = 0; k < 4; k++) begin
            send_narrow(4*25'h51 + k, 1'b1, 4'hf, 32'hc0de0000 + k, 2'd0);
        end
        send_wide(25'h51, 1'b0, 16'h0, 128'h0, 2'd2);
        wait_drain();
        finish_test("mixed address views", e0);
    endtask

    task automatic both_clients();
        int e0;
        e0 = errors;
        check_alt = 1'b1;
        fork
            for (int k = 0; k < 4; k++) begin
                send_narrow(27'h300 + k, 1'b1, 4'hf, 32'hab00 + k, 2'd1);
            end
            for (int k = 0; k < 2; k++) begin
                send_wide(25'h100 + k, 1'b1, 16'hffff, {4{32'h77 + k}}, 2'd2);
            end
        join
        fork
            for (int k = 0; k < 4; k++) begin
                send_narrow(27'h300 + k, 1'b0, 4'h0, 32'h0, 2'(k));
            end
            for (int k = 0; k < 2; k++) begin
                send_wide(25'h100 + k, 1'b0, 16'h0, 128'h0, 2'(k + 1));
            end
        join
        wait_drain();
        check_alt = 1'b0;
        finish_test("both clients at once", e0);
    endtask

    task automatic back_pressure();
        int e0, n;
        mem_pkg::narrow_rsp_t held;
        e0 = errors;
        mem_req_ready <= 1'b0;
        fork
            send_narrow(27'h41, 1'b1, 4'hf, 32'h5a5a1234, 2'd3);
            send_wide(25'h60, 1'b1, 16'h00ff, {4{32'h600d}}, 2'd1);
            begin
                repeat (8) begin
                    @(posedge clk);
                    assert (!narrow_req_ready && !wide_req_ready) else begin
                        $display("client accepted while memory stalled");
                        errors++;
                    end
                end
                mem_req_ready <= 1'b1;
            end
        join
        narrow_rsp_ready <= 1'b0;
        send_narrow(27'h41, 1'b0, 4'h0, 32'h0, 2'd2);
        held.data = ref_get(27'h41);
        held.tag  = 2'd2;
        n = 0;
        while (!narrow_rsp_valid && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (!narrow_rsp_valid) begin
            $display("narrow response never arrived while the client stalled");
            errors++;
        end
        repeat (6) begin
            @(posedge clk);
            assert (narrow_rsp_valid && narrow_rsp == held) else begin
                $display("MISMATCH narrow_rsp got %h expected %h", narrow_rsp, held);
                errors++;
            end
            assert (!mem_rsp_ready) else begin
                $display("MISMATCH mem_rsp_ready got %h expected 0", mem_rsp_ready);
                errors++;
            end
        end
        narrow_rsp_ready <= 1'b1;
        send_wide(25'h60, 1'b0, 16'h0, 128'h0, 2'd3);
        wait_drain();
        finish_test("back-pressure", e0);
    endtask

    task automatic random_traffic();
        int e0, na, wl;
        logic nrw, wrw;
        logic [3:0] nbe;
        logic [15:0] wbe;
        logic [31:0] nd;
        logic [127:0] wd;
        logic [1:0] nt, wt;
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            na = rand_bits(6);          // narrow words 0..63 in lines 0..15.
            nrw = rand_bits(1);
            nbe = rand_bits(4);
            nd = rand_bits(32);
            nt = rand_bits(2);
            wl = 16 + rand_bits(4);     // wide lines 16..31.
            wrw = rand_bits(1);
            wbe = rand_bits(16);
            wd = rand_bits(128);
            wt = rand_bits(2);
            fork
                send_narrow(na, nrw, nbe, nd, nt);
                send_wide(wl, wrw, wbe, wd, wt);
            join
        end
        wait_drain();
        finish_test("random traffic", e0);
    endtask

    initial begin
        #(TEST_COUNT * TEST_CYCLES * 20);
        $display("watchdog expired, a test hung");
        $display("tests failed");
        $finish;
    end

    initial begin
        lfsr = 32'd85;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        check_alt = 1'b0;
        alt_seen = 1'b0;
        prev_src = 1'b0;
        reset = 1'b1;
        narrow_req_valid = 1'b0;
        narrow_req = '0;
        wide_req_valid = 1'b0;
        wide_req = '0;
        narrow_rsp_ready = 1'b1;
        wide_rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        narrow_write_read();
        wide_write_read();
        mixed_views();
        both_clients();
        back_pressure();
        random_traffic();
        $display("summary: %0d ok, %0d bad, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verilog/mem_adapter_top.sv */
`timescale 1ns/1ns

module mem_adapter_top (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  narrow_req_valid,
    input  mem_pkg::narrow_req_t  narrow_req,
    output logic                  narrow_req_ready,

    output logic                  narrow_rsp_valid,
    output mem_pkg::narrow_rsp_t  narrow_rsp,
    input  logic                  narrow_rsp_ready,

    input  logic                  wide_req_valid,
    input  mem_pkg::wide_req_t    wide_req,
    output logic                  wide_req_ready,

    output logic                  wide_rsp_valid,
    output mem_pkg::wide_rsp_t    wide_rsp,
    input  logic                  wide_rsp_ready,

    output logic                  mem_req_valid,
    output mem_pkg::mem_req_t     mem_req,
    input  logic                  mem_req_ready,

    input  logic                  mem_rsp_valid,
    input  mem_pkg::mem_rsp_t     mem_rsp,
    output logic                  mem_rsp_ready
);

    // narrow side of the arbiter.
    logic                narrow_port_req_valid;
    mem_pkg::port_req_t  narrow_port_req;
    logic                narrow_port_req_ready;
    logic                narrow_port_rsp_valid;
    mem_pkg::port_rsp_t  narrow_port_rsp;
    logic                narrow_port_rsp_ready;

    // wide side.
    logic                wide_port_req_valid;
    mem_pkg::port_req_t  wide_port_req;
    logic                wide_port_req_ready;
    logic                wide_port_rsp_valid;
    mem_pkg::port_rsp_t  wide_port_rsp;
    logic                wide_port_rsp_ready;

    mem_width_adapter #(
        .src_req_t (mem_pkg::narrow_req_t),
        .src_rsp_t (mem_pkg::narrow_rsp_t),
        .dst_req_t (mem_pkg::port_req_t),
        .dst_rsp_t (mem_pkg::port_rsp_t)
    ) narrow_adapter_i (
        .clk           (clk),
        .reset         (reset),
        .src_req_valid (narrow_req_valid),
        .src_req       (narrow_req),
        .src_req_ready (narrow_req_ready),
        .dst_req_valid (narrow_port_req_valid),
        .dst_req       (narrow_port_req),
        .dst_req_ready (narrow_port_req_ready),
        .dst_rsp_valid (narrow_port_rsp_valid),
        .dst_rsp       (narrow_port_rsp),
        .dst_rsp_ready (narrow_port_rsp_ready),
        .src_rsp_valid (narrow_rsp_valid),
        .src_rsp       (narrow_rsp),
        .src_rsp_ready (narrow_rsp_ready)
    );

    mem_width_adapter #(
        .src_req_t (mem_pkg::wide_req_t),
        .src_rsp_t (mem_pkg::wide_rsp_t),
        .dst_req_t (mem_pkg::port_req_t),
        .dst_rsp_t (mem_pkg::port_rsp_t)
    ) wide_adapter_i (
        .clk           (clk),
        .reset         (reset),
        .src_req_valid (wide_req_valid),
        .src_req       (wide_req),
        .src_req_ready (wide_req_ready),
        .dst_req_valid (wide_port_req_valid),
        .dst_req       (wide_port_req),
        .dst_req_ready (wide_port_req_ready),
        .dst_rsp_valid (wide_port_rsp_valid),
        .dst_rsp       (wide_port_rsp),
        .dst_rsp_ready (wide_port_rsp_ready),
        .src_rsp_valid (wide_rsp_valid),
        .src_rsp       (wide_rsp),
        .src_rsp_ready (wide_rsp_ready)
    );

    // side 0 is narrow, side 1 wide.
    mem_arbiter mem_arbiter_i (
        .clk            (clk),
        .reset          (reset),
        .in0_req_valid  (narrow_port_req_valid),
        .in0_req        (narrow_port_req),
        .in0_req_ready  (narrow_port_req_ready),
        .in1_req_valid  (wide_port_req_valid),
        .in1_req        (wide_port_req),
        .in1_req_ready  (wide_port_req_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .out0_rsp_valid (narrow_port_rsp_valid),
        .out0_rsp       (narrow_port_rsp),
        .out0_rsp_ready (narrow_port_rsp_ready),
        .out1_rsp_valid (wide_port_rsp_valid),
        .out1_rsp       (wide_port_rsp),
        .out1_rsp_ready (wide_port_rsp_ready)
    );

endmodule

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ns

`include "mem_defines.svh"

module mem_arbiter (
    input  logic                clk,
    input  logic                reset,

    input  logic                in0_req_valid,
    input  mem_pkg::port_req_t  in0_req,
    output logic                in0_req_ready,

    input  logic                in1_req_valid,
    input  mem_pkg::port_req_t  in1_req,
    output logic                in1_req_ready,

    output logic                mem_req_valid,
    output mem_pkg::mem_req_t   mem_req,
    input  logic                mem_req_ready,

    input  logic                mem_rsp_valid,
    input  mem_pkg::mem_rsp_t   mem_rsp,
    output logic                mem_rsp_ready,

    output logic                out0_rsp_valid,
    output mem_pkg::port_rsp_t  out0_rsp,
    input  logic                out0_rsp_ready,

    output logic                out1_rsp_valid,
    output mem_pkg::port_rsp_t  out1_rsp,
    input  logic                out1_rsp_ready
);

    logic               rr_ptr;     // side preferred next.
    logic               lock_q;
    logic               lock_sel_q;
    logic               rr_sel;
    logic               sel;
    logic               req_fire;
    logic               rsp_sel;
    mem_pkg::port_req_t req_w;

    assign rr_sel = in1_req_valid && (!in0_req_valid || rr_ptr);

    // a stalled grant is kept so the payload holds.
    assign sel      = lock_q ? lock_sel_q : rr_sel;
    assign req_w    = sel ? in1_req : in0_req;
    assign req_fire = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= 1'b0;
            lock_q <= 1'b0;
        end else begin
            lock_q <= mem_req_valid && !mem_req_ready;
            if (req_fire) begin
                rr_ptr <= !sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        lock_sel_q <= sel;
    end

    assign mem_req_valid = in0_req_valid || in1_req_valid;
    assign in0_req_ready = mem_req_ready && !sel;
    assign in1_req_ready = mem_req_ready && sel;

    always_comb begin
        mem_req        = '0;
        mem_req.addr   = req_w.addr;
        mem_req.rw     = req_w.rw;
        mem_req.byteen = req_w.byteen;
        mem_req.data   = req_w.data;
        mem_req.tag    = {sel, req_w.tag};
    end

    // responses steered by the source bit.
    assign rsp_sel = mem_rsp.tag[`MEM_TAG_WIDTH-1];

    assign out0_rsp_valid = mem_rsp_valid && !rsp_sel;
    assign out1_rsp_valid = mem_rsp_valid && rsp_sel;
    assign mem_rsp_ready  = rsp_sel ? out1_rsp_ready : out0_rsp_ready;

    always_comb begin
        out0_rsp      = '0;
        out0_rsp.data = mem_rsp.data;
        out0_rsp.tag  = mem_rsp.tag[`PORT_TAG_WIDTH-1:0];
        out1_rsp      = out0_rsp;
    end

endmodule

/* verilog/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// shared memory port, 64-bit words.
`define MEM_DATA_WIDTH     64
`define MEM_ADDR_WIDTH     26
`define MEM_TAG_WIDTH      4

// narrow client, 32-bit word address.
`define NARROW_DATA_WIDTH  32
`define NARROW_ADDR_WIDTH  27

// wide client, 128-bit line address.
`define WIDE_DATA_WIDTH    128
`define WIDE_ADDR_WIDTH    25

`define CLIENT_TAG_WIDTH   2
// client tag plus lane or spare bit.
`define PORT_TAG_WIDTH     3

`endif

/* verilog/mem_pkg.sv */
`include "mem_defines.svh"

package mem_pkg;

    typedef struct packed {
        logic [`NARROW_ADDR_WIDTH-1:0]     addr;
        logic                              rw;     // 1 = write.
        logic [`NARROW_DATA_WIDTH/8-1:0]   byteen;
        logic [`NARROW_DATA_WIDTH-1:0]     data;
        logic [`CLIENT_TAG_WIDTH-1:0]      tag;
    } narrow_req_t;

    typedef struct packed {
        logic [`NARROW_DATA_WIDTH-1:0]     data;
        logic [`CLIENT_TAG_WIDTH-1:0]      tag;
    } narrow_rsp_t;

    typedef struct packed {
        logic [`WIDE_ADDR_WIDTH-1:0]       addr;
        logic                              rw;
        logic [`WIDE_DATA_WIDTH/8-1:0]     byteen;
        logic [`WIDE_DATA_WIDTH-1:0]       data;
        logic [`CLIENT_TAG_WIDTH-1:0]      tag;
    } wide_req_t;

    typedef struct packed {
        logic [`WIDE_DATA_WIDTH-1:0]       data;
        logic [`CLIENT_TAG_WIDTH-1:0]      tag;
    } wide_rsp_t;

    // adapter side of the arbiter.
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0]        addr;
        logic                              rw;
        logic [`MEM_DATA_WIDTH/8-1:0]      byteen;
        logic [`MEM_DATA_WIDTH-1:0]        data;
        logic [`PORT_TAG_WIDTH-1:0]        tag;
    } port_req_t;

    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]        data;
        logic [`PORT_TAG_WIDTH-1:0]        tag;
    } port_rsp_t;

    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0]        addr;
        logic                              rw;
        logic [`MEM_DATA_WIDTH/8-1:0]      byteen;
        logic [`MEM_DATA_WIDTH-1:0]        data;
        logic [`MEM_TAG_WIDTH-1:0]         tag;  // top bit names the source.
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]        data;
        logic [`MEM_TAG_WIDTH-1:0]         tag;
    } mem_rsp_t;

endpackage

/* verilog/mem_width_adapter.sv */
`timescale 1ns/1ns

module mem_width_adapter #(
    parameter type src_req_t = mem_pkg::narrow_req_t,
    parameter type src_rsp_t = mem_pkg::narrow_rsp_t,
    parameter type dst_req_t = mem_pkg::port_req_t,
    parameter type dst_rsp_t = mem_pkg::port_rsp_t
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     src_req_valid,
    input  src_req_t src_req,
    output logic     src_req_ready,

    output logic     dst_req_valid,
    output dst_req_t dst_req,
    input  logic     dst_req_ready,

    input  logic     dst_rsp_valid,
    input  dst_rsp_t dst_rsp,
    output logic     dst_rsp_ready,

    output logic     src_rsp_valid,
    output src_rsp_t src_rsp,
    input  logic     src_rsp_ready
);

    // widths come straight from the payload fields.
    localparam int SRC_DW = $bits(src_req.data);
    localparam int DST_DW = $bits(dst_req.data);
    localparam int SRC_BW = $bits(src_req.byteen);
    localparam int DST_BW = $bits(dst_req.byteen);
    localparam int SRC_AW = $bits(src_req.addr);
    localparam int DST_AW = $bits(dst_req.addr);
    localparam int SRC_TW = $bits(src_req.tag);
    localparam int DST_TW = $bits(dst_req.tag);

    localparam int RATIO = (DST_DW > SRC_DW) ? (DST_DW / SRC_DW) : (SRC_DW / DST_DW);
    localparam int D     = $clog2(RATIO);

    if (DST_DW > SRC_DW) begin : g_upsize

        logic [D-1:0] req_lane;
        logic [D-1:0] rsp_lane;
        logic [RATIO-1:0][SRC_DW-1:0] rsp_lanes;

        assign req_lane  = src_req.addr[D-1:0];
        assign rsp_lane  = dst_rsp.tag[D-1:0];  // lane rides in the low tag bits.
        assign rsp_lanes = dst_rsp.data;

        always_comb begin
            dst_req        = '0;
            dst_req.addr   = DST_AW'(src_req.addr[SRC_AW-1:D]);
            dst_req.rw     = src_req.rw;
            dst_req.byteen = DST_BW'(src_req.byteen) << (req_lane * SRC_BW);
            dst_req.data   = DST_DW'(src_req.data) << (req_lane * SRC_DW);
            dst_req.tag    = DST_TW'({src_req.tag, req_lane});
        end

        assign dst_req_valid = src_req_valid;
        assign src_req_ready = dst_req_ready;

        always_comb begin
            src_rsp      = '0;
            src_rsp.data = rsp_lanes[rsp_lane];
            src_rsp.tag  = dst_rsp.tag[SRC_TW+D-1:D];
        end

        assign src_rsp_valid = dst_rsp_valid;
        assign dst_rsp_ready = src_rsp_ready;

    end else begin : g_downsize

        localparam logic [D-1:0] LAST = D'(RATIO - 1);

        logic [D-1:0] req_ctr;
        logic [D-1:0] rsp_ctr;
        logic         req_fire;
        logic         rsp_fire;

        logic [RATIO-1:0][DST_DW-1:0] req_data_lanes;
        logic [RATIO-1:0][DST_BW-1:0] req_byteen_lanes;
        logic [RATIO-1:0][DST_DW-1:0] rsp_buf;
        logic [RATIO-1:0][DST_DW-1:0] rsp_data_n;
        logic [DST_TW-1:0]            rsp_tag_q;
        logic [DST_TW-1:0]            rsp_tag_w;

        assign req_fire = dst_req_valid && dst_req_ready;
        assign rsp_fire = dst_rsp_valid && dst_rsp_ready;

        assign req_data_lanes   = src_req.data;
        assign req_byteen_lanes = src_req.byteen;

        always_ff @(posedge clk) begin
            if (reset) begin
                req_ctr <= '0;
                rsp_ctr <= '0;
            end else begin
                if (req_fire) begin
                    req_ctr <= req_ctr + 1'b1;
                end
                if (rsp_fire) begin
                    rsp_ctr <= rsp_ctr + 1'b1;
                end
            end
        end

        // earlier beats and the first tag wait here.
        always_ff @(posedge clk) begin
            if (rsp_fire) begin
                rsp_buf[rsp_ctr] <= dst_rsp.data;
                if (rsp_ctr == '0) begin
                    rsp_tag_q <= dst_rsp.tag;
                end
            end
        end

        always_comb begin
            dst_req        = '0;
            dst_req.addr   = DST_AW'({src_req.addr, req_ctr});
            dst_req.rw     = src_req.rw;
            dst_req.byteen = req_byteen_lanes[req_ctr];
            dst_req.data   = req_data_lanes[req_ctr];
            dst_req.tag    = DST_TW'(src_req.tag);  // zero-extended.
        end

        assign dst_req_valid = src_req_valid;
        assign src_req_ready = dst_req_ready && (req_ctr == LAST);  // only on the last beat.

        always_comb begin
            rsp_data_n          = rsp_buf;
            rsp_data_n[rsp_ctr] = dst_rsp.data;
        end

        assign rsp_tag_w = (rsp_ctr != '0) ? rsp_tag_q : dst_rsp.tag;

        always_comb begin
            src_rsp      = '0;
            src_rsp.data = rsp_data_n;
            src_rsp.tag  = rsp_tag_w[SRC_TW-1:0];
        end

        // early beats never wait on the client.
        assign src_rsp_valid = dst_rsp_valid && (rsp_ctr == LAST);
        assign dst_rsp_ready = src_rsp_ready || (rsp_ctr != LAST);

    end

endmodule
